// File: tests/snake_golden.txt
// record: type _ frame or address _ x or data _ y _ rrggbb, all hex
// type 1 writes data to address, type 2 probes pixel x,y of a frame, type 0 ends
// background 20 40 60
1_003_020_000_000000
1_004_040_000_000000
1_005_060_000_000000
// apple at tile 5,3
1_000_005_000_000000
1_001_003_000_000000
1_002_001_000_000000
// head at 10,4 and body at 11,4
1_000_00a_000_000000
1_001_004_000_000000
1_002_002_000_000000
1_000_00b_000_000000
1_002_003_000_000000
// walls in two corners
1_000_000_000_000000
1_001_000_000_000000
1_002_004_000_000000
1_000_027_000_000000
1_001_01d_000_000000
1_002_004_000_000000
// frame 1, sprites and background
2_001_000_000_404040
2_001_005_005_808080
2_001_028_008_204060
2_001_050_032_000000
2_001_058_038_f80000
2_001_0a8_046_00fc00
2_001_0af_046_000000
2_001_0b0_048_007c00
2_001_0b4_048_00fc00
2_001_2bc_064_000000
2_001_276_1d6_808080
2_001_28a_1d6_000000
2_001_27f_1df_404040
2_001_064_1f4_000000
// clear apple, commit at column 45, kind 7 on the head, new background
1_000_005_000_000000
1_001_003_000_000000
1_002_000_000_000000
1_000_02d_000_000000
1_002_004_000_000000
1_000_00a_000_000000
1_001_004_000_000000
1_002_007_000_000000
1_003_00a_000_000000
1_004_0b0_000_000000
1_005_0c8_000_000000
// frame 2, overwrite and range
2_002_000_000_404040
2_002_028_008_0ab0c8
2_002_050_032_0ab0c8
2_002_058_038_0ab0c8
2_002_0a8_046_0ab0c8
2_002_058_048_0ab0c8
2_002_0b4_048_00fc00
2_002_2d0_0c8_000000
2_002_140_208_000000
0_000_000_000_000000

// File: filelist.f
logic/snake_pkg.sv
logic/vga_timing.sv
logic/tile_regs.sv
logic/sprite_rom.sv
logic/pixel_pipeline.sv
logic/snake_display.sv
tests/snake_display_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the snake display testbench with verilator
# a failed build or run leaves the fail message in the log too

cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module snake_display_tb -f filelist.f > "$log" 2>&1 &&
  ./obj_dir/Vsnake_display_tb >> "$log" 2>&1 ||
  echo "** FAIL **" >> "$log"

grep -q '^\*\* FAIL \*\*$' "$log" &&
  { echo "simulation failed, see $log"; exit 1; } ||
  { echo "simulation passed, see $log"; exit 0; }

// File: tests/snake_display_tb.sv
// testbench for the snake tile display
// replays host writes and pixel probes from a golden file, checks
// every cycle's sync, blank and blanking colour against the raster
// rules and each probed pixel against its expected colour
`timescale 1ns/1ps

module snake_display_tb;

  import snake_pkg::*;

  localparam longint clk_period   = 40;
  localparam int     golden_depth = 128;

  // raster geometry in cycles and lines
  localparam longint line_len    = longint'(h_total);
  localparam longint field_lines = longint'(v_total);
  localparam longint frame_len   = line_len * field_lines;
  localparam longint vis_cycles  = longint'(h_active);
  localparam longint vis_lines   = longint'(v_active);
  localparam longint hs_start    = longint'(h_active + h_front_porch);
  localparam longint hs_stop     = hs_start + longint'(h_sync);
  localparam longint vs_start    = longint'(v_active + v_front_porch);
  localparam longint vs_stop     = vs_start + longint'(v_sync);
  localparam longint latency     = longint'(pipe_depth);

  logic       clk;
  logic       reset;
  logic [7:0] writedata;
  logic       write;
  logic       chipselect;
  logic [2:0] address;
  logic [7:0] vga_r;
  logic [7:0] vga_g;
  logic [7:0] vga_b;
  logic       vga_clk;
  logic       vga_hs;
  logic       vga_vs;
  logic       vga_blank_n;
  logic       vga_sync_n;

  // one record per word: type, frame or address, x or data, y, rgb
  logic [63:0] golden [golden_depth];

  longint cyc;
  longint watch_cycles;
  bit     loaded;
  int     timing_errors;
  int     pixel_errors;
  int     setup_errors;

  snake_display UUT (
    .clk         (clk),
    .reset       (reset),
    .writedata   (writedata),
    .write       (write),
    .chipselect  (chipselect),
    .address     (address),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b),
    .vga_clk     (vga_clk),
    .vga_hs      (vga_hs),
    .vga_vs      (vga_vs),
    .vga_blank_n (vga_blank_n),
    .vga_sync_n  (vga_sync_n)
  );

  // ----------------------------------------------------------------------------
  // clock and cycle count
  // ----------------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // rising edges since reset release, matches the raster counters
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 64'd1;
    end
  end

  // ----------------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------------

  task automatic compare_value(input string sig, input logic [7:0] got,
                               input logic [7:0] exp, input bit raster);
    assert (got == exp) else begin
      $display("** Error: %s expected %h got %h at cycle %0d", sig, exp, got, cyc);
      if (raster) begin
        timing_errors++;
      end else begin
        pixel_errors++;
      end
    end
  endtask

  // outputs now show the counters of pipe_depth cycles ago
  task automatic check_raster();
    longint k;
    longint hpos;
    longint vpos;
    logic   exp_hs;
    logic   exp_vs;
    logic   exp_blank;
    if (cyc < latency) begin
      // still the reset values of the delay line
      exp_hs    = 1'b1;
      exp_vs    = 1'b1;
      exp_blank = 1'b0;
    end else begin
      k         = cyc - latency;
      hpos      = k % line_len;
      vpos      = (k / line_len) % field_lines;
      exp_hs    = !((hpos >= hs_start) && (hpos < hs_stop));
      exp_vs    = !((vpos >= vs_start) && (vpos < vs_stop));
      exp_blank = (hpos < vis_cycles) && (vpos < vis_lines);
    end
    compare_value("vga_hs", 8'(vga_hs), 8'(exp_hs), 1'b1);
    compare_value("vga_vs", 8'(vga_vs), 8'(exp_vs), 1'b1);
    compare_value("vga_blank_n", 8'(vga_blank_n), 8'(exp_blank), 1'b1);
    // pixel clock is the undelayed hcount lsb
    compare_value("vga_clk", 8'(vga_clk), 8'((cyc % line_len) & 64'd1), 1'b1);
    compare_value("vga_sync_n", 8'(vga_sync_n), 8'h00, 1'b1);
    // black whenever blanked
    if (!exp_blank) begin
      compare_value("vga_r", vga_r, 8'h00, 1'b1);
      compare_value("vga_g", vga_g, 8'h00, 1'b1);
      compare_value("vga_b", vga_b, 8'h00, 1'b1);
    end
  endtask

  always @(negedge clk) begin
    if (!reset) begin
      check_raster();
    end
  end

  // ----------------------------------------------------------------------------
  // bus and probes, all called on a falling edge
  // ----------------------------------------------------------------------------

  task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
    chipselect = 1'b1;
    write      = 1'b1;
    address    = addr;
    writedata  = data;
    @(negedge clk);
    chipselect = 1'b0;
    write      = 1'b0;
  endtask

  task automatic probe_pixel(input longint frame, input longint px, input longint py,
                             input logic [7:0] exp_r, input logic [7:0] exp_g,
                             input logic [7:0] exp_b);
    longint target;
    // first cycle of the pixel at the outputs
    target = frame * frame_len + py * line_len + 2 * px + latency;
    if (cyc > target) begin
      $display("probe of frame %0d at (%0d, %0d) came after its pixel had passed",
               frame, px, py);
      setup_errors++;
    end else begin
      while (cyc < target) begin
        @(negedge clk);
      end
      compare_value("vga_r", vga_r, exp_r, 1'b0);
      compare_value("vga_g", vga_g, exp_g, 1'b0);
      compare_value("vga_b", vga_b, exp_b, 1'b0);
    end
  endtask

  // last probed frame sets the watchdog limit
  task automatic scan_golden();
    longint last_frame;
    int     probes;
    last_frame = 0;
    probes     = 0;
    for (int i = 0; i < golden_depth; i++) begin
      if (golden[i][63:60] == 4'h0) begin
        break;
      end
      if (golden[i][63:60] == 4'h2) begin
        probes++;
        if (longint'(golden[i][59:48]) > last_frame) begin
          last_frame = longint'(golden[i][59:48]);
        end
      end
    end
    if (probes == 0) begin
      $display("golden file holds no pixel probes");
      setup_errors++;
    end
    watch_cycles = (last_frame + 1 + 2) * frame_len;
  endtask

  // ----------------------------------------------------------------------------
  // watchdog
  // ----------------------------------------------------------------------------

  initial begin
    wait (loaded);
    #(watch_cycles * clk_period);
    $display("watchdog expired after %0d cycles without the test ending", watch_cycles);
    $display("** FAIL **");
    $finish;
  end

  // ----------------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------------

  initial begin
    int          idx;
    logic [63:0] rec;
    bit          done;
    reset         = 1'b1;
    chipselect    = 1'b0;
    write         = 1'b0;
    address       = 3'd0;
    writedata     = 8'h00;
    loaded        = 1'b0;
    timing_errors = 0;
    pixel_errors  = 0;
    setup_errors  = 0;
    watch_cycles  = 0;
    $readmemh("tests/snake_golden.txt", golden);
    scan_golden();
    loaded = 1'b1;

    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    idx  = 0;
    done = 1'b0;
    while (!done && (idx < golden_depth)) begin
      rec = golden[idx];
      case (rec[63:60])
        4'h0: done = 1'b1;
        4'h1: write_reg(rec[50:48], rec[43:36]);
        4'h2: probe_pixel(longint'(rec[59:48]), longint'(rec[47:36]),
                          longint'(rec[35:24]), rec[23:16], rec[15:8], rec[7:0]);
        default: begin
          $display("golden record %0d has unknown type %h", idx, rec[63:60]);
          setup_errors++;
        end
      endcase
      idx++;
    end

    @(negedge clk);
    $display("errors: timing %0d, pixel %0d, setup %0d",
             timing_errors, pixel_errors, setup_errors);
    if ((timing_errors + pixel_errors + setup_errors) == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: logic/snake_display.sv
// snake tile display top level
// avalon byte registers in, vga out; joins the raster generator,
// register block with tile map, sprite table and pixel pipeline
`timescale 1ns/1ps

module snake_display (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] writedata,
  input  logic       write,
  input  logic       chipselect,
  input  logic [2:0] address,
  output logic [7:0] vga_r,
  output logic [7:0] vga_g,
  output logic [7:0] vga_b,
  output logic       vga_clk,
  output logic       vga_hs,
  output logic       vga_vs,
  output logic       vga_blank_n,
  output logic       vga_sync_n
);

  import snake_pkg::*;

  // raster
  logic [10:0] hcount;
  logic [9:0]  vcount;
  logic        hsync;
  logic        vsync;
  logic        blank_n;

  // map read
  logic [5:0]  rd_col;
  logic [4:0]  rd_row;
  tile_kind_t  map_kind;

  // sprite lookup
  tile_kind_t  sprite_kind;
  logic [3:0]  u;
  logic [3:0]  v;
  logic [15:0] color;

  // background
  logic [7:0]  bg_r;
  logic [7:0]  bg_g;
  logic [7:0]  bg_b;

  vga_timing timing (
    .clk        (clk),
    .reset      (reset),
    .hcount     (hcount),
    .vcount     (vcount),
    .hsync      (hsync),
    .vsync      (vsync),
    .blank_n    (blank_n),
    .vga_clk    (vga_clk),
    .vga_sync_n (vga_sync_n)
  );

  tile_regs regs (
    .clk        (clk),
    .reset      (reset),
    .chipselect (chipselect),
    .write      (write),
    .address    (address),
    .writedata  (writedata),
    .rd_col     (rd_col),
    .rd_row     (rd_row),
    .map_kind   (map_kind),
    .bg_r       (bg_r),
    .bg_g       (bg_g),
    .bg_b       (bg_b)
  );

  sprite_rom sprites (
    .clk   (clk),
    .kind  (sprite_kind),
    .u     (u),
    .v     (v),
    .color (color)
  );

  pixel_pipeline pipe (
    .clk         (clk),
    .reset       (reset),
    .hcount      (hcount),
    .vcount      (vcount),
    .hsync       (hsync),
    .vsync       (vsync),
    .blank_n     (blank_n),
    .rd_col      (rd_col),
    .rd_row      (rd_row),
    .map_kind    (map_kind),
    .sprite_kind (sprite_kind),
    .u           (u),
    .v           (v),
    .color       (color),
    .bg_r        (bg_r),
    .bg_g        (bg_g),
    .bg_b        (bg_b),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b),
    .vga_hs      (vga_hs),
    .vga_vs      (vga_vs),
    .vga_blank_n (vga_blank_n)
  );

endmodule

// File: logic/pixel_pipeline.sv
// three stage pixel pipeline
// stage 1 map read at the beam tile, stage 2 sprite lookup,
// stage 3 colour select; syncs and blank delayed to stay aligned
`timescale 1ns/1ps

module pixel_pipeline (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [10:0]           hcount,
  input  logic [9:0]            vcount,
  input  logic                  hsync,
  input  logic                  vsync,
  input  logic                  blank_n,
  output logic [5:0]            rd_col,
  output logic [4:0]            rd_row,
  input  snake_pkg::tile_kind_t map_kind,
  output snake_pkg::tile_kind_t sprite_kind,
  output logic [3:0]            u,
  output logic [3:0]            v,
  input  logic [15:0]           color,
  input  logic [7:0]            bg_r,
  input  logic [7:0]            bg_g,
  input  logic [7:0]            bg_b,
  output logic [7:0]            vga_r,
  output logic [7:0]            vga_g,
  output logic [7:0]            vga_b,
  output logic                  vga_hs,
  output logic                  vga_vs,
  output logic                  vga_blank_n
);

  import snake_pkg::*;

  // sync and blank delay lines, one tap per stage
  logic [pipe_depth-1:0] hs_pipe;
  logic [pipe_depth-1:0] vs_pipe;
  logic [pipe_depth-1:0] blank_pipe;

  // kind carried alongside the sprite lookup
  tile_kind_t kind_d;

  // --------------------------------------------------------------------------
  // stage 1, tile address
  // --------------------------------------------------------------------------

  // two cycles per pixel, so tile column starts at hcount bit 5
  assign rd_col = hcount[10:5];
  // bit 9 only set below the visible area
  assign rd_row = vcount[8:4];

  // in-tile offset waits for the map read
  always_ff @(posedge clk) begin
    u <= hcount[4:1];
    v <= vcount[3:0];
  end

  // --------------------------------------------------------------------------
  // stage 2, sprite lookup
  // --------------------------------------------------------------------------

  assign sprite_kind = map_kind;

  always_ff @(posedge clk) begin
    kind_d <= map_kind;
  end

  // --------------------------------------------------------------------------
  // stage 3, colour select and delays
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      // syncs idle high
      hs_pipe    <= '1;
      vs_pipe    <= '1;
      blank_pipe <= '0;
    end else begin
      hs_pipe    <= {hs_pipe[pipe_depth-2:0], hsync};
      vs_pipe    <= {vs_pipe[pipe_depth-2:0], vsync};
      blank_pipe <= {blank_pipe[pipe_depth-2:0], blank_n};
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vga_r <= '0;
      vga_g <= '0;
      vga_b <= '0;
    end else if (!blank_pipe[pipe_depth-2]) begin
      // black during blanking
      vga_r <= '0;
      vga_g <= '0;
      vga_b <= '0;
    end else if (kind_d == tile_empty) begin
      vga_r <= bg_r;
      vga_g <= bg_g;
      vga_b <= bg_b;
    end else begin
      // rgb565 widened to 8 bits a channel
      vga_r <= {color[15:11], 3'b000};
      vga_g <= {color[10:5], 2'b00};
      vga_b <= {color[4:0], 3'b000};
    end
  end

  assign vga_hs      = hs_pipe[pipe_depth-1];
  assign vga_vs      = vs_pipe[pipe_depth-1];
  assign vga_blank_n = blank_pipe[pipe_depth-1];

endmodule

// File: logic/sprite_rom.sv
// generated sprite table
// one rgb565 colour per tile kind and in-tile pixel, registered;
// outline colour on the tile edge, fill colour inside
`timescale 1ns/1ps

module sprite_rom (
  input  logic                  clk,
  input  snake_pkg::tile_kind_t kind,
  input  logic [3:0]            u,
  input  logic [3:0]            v,
  output logic [15:0]           color
);

  import snake_pkg::*;

  localparam logic [3:0] last_px = 4'(tile_px - 1);

  logic on_edge;
  logic known_kind;

  // one pixel ring around the tile
  assign on_edge = (u == 4'd0) || (u == last_px) || (v == 4'd0) || (v == last_px);

  // empty or out of range kinds have no sprite
  assign known_kind = (kind != tile_empty) && (kind <= tile_wall);

  // --------------------------------------------------------------------------
  // lookup
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!known_kind) begin
      // background substituted downstream
      color <= 16'h0000;
    end else if (on_edge) begin
      color <= outline_color[kind];
    end else begin
      color <= fill_color[kind];
    end
  end

endmodule

// File: logic/tile_regs.sv
// host register block and tile map
// decodes avalon byte writes into pending position, background colour
// and tile commits; holds the 40x30 map with one registered read port
`timescale 1ns/1ps

module tile_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   chipselect,
  input  logic                   write,
  input  logic [2:0]             address,
  input  logic [7:0]             writedata,
  input  logic [5:0]             rd_col,
  input  logic [4:0]             rd_row,
  output snake_pkg::tile_kind_t  map_kind,
  output logic [7:0]             bg_r,
  output logic [7:0]             bg_g,
  output logic [7:0]             bg_b
);

  import snake_pkg::*;

  localparam int map_size = map_cols * map_rows;
  localparam int idx_w    = $clog2(map_size);

  logic [7:0] pend_col;
  logic [7:0] pend_row;
  logic       wr_en;
  logic       commit_ok;
  tile_kind_t wr_kind;

  tile_kind_t tile_map [map_size];

  // row-major linear index
  function automatic logic [idx_w-1:0] map_index(input logic [idx_w-1:0] row,
                                                 input logic [idx_w-1:0] col);
    map_index = row * idx_w'(map_cols) + col;
  endfunction

  assign wr_en = chipselect && write;

  // range check on the pending position
  assign commit_ok = (pend_col < 8'(map_cols)) && (pend_row < 8'(map_rows));

  // unknown kinds fall back to empty
  assign wr_kind = (writedata > 8'(tile_wall)) ? tile_empty : tile_kind_t'(writedata[2:0]);

  // --------------------------------------------------------------------------
  // write decode
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pend_col <= '0;
      pend_row <= '0;
      bg_r     <= '0;
      bg_g     <= '0;
      bg_b     <= '0;
      for (int i = 0; i < map_size; i++) begin
        tile_map[i] <= tile_empty;
      end
    end else if (wr_en) begin
      case (reg_addr_t'(address))
        reg_col:  pend_col <= writedata;
        reg_row:  pend_row <= writedata;
        reg_kind: begin
          // commit lands on the same edge as the kind write
          if (commit_ok) begin
            tile_map[map_index(idx_w'(pend_row), idx_w'(pend_col))] <= wr_kind;
          end
        end
        reg_bg_r: bg_r <= writedata;
        reg_bg_g: bg_g <= writedata;
        reg_bg_b: bg_b <= writedata;
        // 6 and 7 unmapped
        default: ;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // read port
  // --------------------------------------------------------------------------

  // beam off the map during blanking reads as empty
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      map_kind <= tile_empty;
    end else if ((rd_col < col_w'(map_cols)) && (rd_row < row_w'(map_rows))) begin
      map_kind <= tile_map[map_index(idx_w'(rd_row), idx_w'(rd_col))];
    end else begin
      map_kind <= tile_empty;
    end
  end

endmodule

// File: logic/vga_timing.sv
// vga raster generator
// 640x480 frame from a 50 MHz clock, each pixel spans two cycles
// two wrapping counters, sync and blank decoded from their values
`timescale 1ns/1ps

module vga_timing (
  input  logic        clk,
  input  logic        reset,
  output logic [10:0] hcount,
  output logic [9:0]  vcount,
  output logic        hsync,
  output logic        vsync,
  output logic        blank_n,
  output logic        vga_clk,
  output logic        vga_sync_n
);

  import snake_pkg::*;

  // sync pulse windows
  localparam logic [10:0] hs_start = h_active + h_front_porch;
  localparam logic [10:0] hs_end   = hs_start + h_sync;
  localparam logic [9:0]  vs_start = v_active + v_front_porch;
  localparam logic [9:0]  vs_end   = vs_start + v_sync;

  logic end_of_line;
  logic end_of_field;

  assign end_of_line  = (hcount == h_total - 11'd1);
  assign end_of_field = (vcount == v_total - 10'd1);

  // --------------------------------------------------------------------------
  // counters
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hcount <= '0;
    end else if (end_of_line) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + 11'd1;
    end
  end

  // line counter steps once per line
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vcount <= '0;
    end else if (end_of_line) begin
      if (end_of_field) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 10'd1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // decode
  // --------------------------------------------------------------------------

  // both syncs active low
  assign hsync = !((hcount >= hs_start) && (hcount < hs_end));
  assign vsync = !((vcount >= vs_start) && (vcount < vs_end));

  assign blank_n = (hcount < h_active) && (vcount < v_active);

  // 25 MHz pixel clock
  assign vga_clk = hcount[0];

  // no sync on green
  assign vga_sync_n = 1'b0;

endmodule

// File: logic/snake_pkg.sv
// snake tile display shared definitions
// vga raster timing, tile geometry, host register map,
// tile kinds and the rgb565 sprite palette
package snake_pkg;

  // --------------------------------------------------------------------------
  // raster timing, 50 MHz clock, one pixel every two cycles
  // --------------------------------------------------------------------------

  // horizontal, in clock cycles
  localparam logic [10:0] h_active      = 11'd1280;
  localparam logic [10:0] h_front_porch = 11'd32;
  localparam logic [10:0] h_sync        = 11'd192;
  localparam logic [10:0] h_back_porch  = 11'd96;
  localparam logic [10:0] h_total       = h_active + h_front_porch + h_sync + h_back_porch;

  // vertical, in lines
  localparam logic [9:0] v_active      = 10'd480;
  localparam logic [9:0] v_front_porch = 10'd10;
  localparam logic [9:0] v_sync        = 10'd2;
  localparam logic [9:0] v_back_porch  = 10'd33;
  localparam logic [9:0] v_total       = v_active + v_front_porch + v_sync + v_back_porch;

  // --------------------------------------------------------------------------
  // tile geometry
  // --------------------------------------------------------------------------

  // tile edge in screen pixels
  localparam int tile_px  = 16;
  localparam int map_cols = 40;
  localparam int map_rows = 30;
  localparam int col_w    = 6;
  localparam int row_w    = 5;

  // counter value to colour output
  localparam int pipe_depth = 3;

  // --------------------------------------------------------------------------
  // encodings
  // --------------------------------------------------------------------------

  typedef enum logic [2:0] {
    tile_empty = 3'd0,
    tile_apple = 3'd1,
    tile_head  = 3'd2,
    tile_body  = 3'd3,
    tile_wall  = 3'd4
  } tile_kind_t;

  // host byte registers
  typedef enum logic [2:0] {
    reg_col  = 3'd0,
    reg_row  = 3'd1,
    reg_kind = 3'd2,
    reg_bg_r = 3'd3,
    reg_bg_g = 3'd4,
    reg_bg_b = 3'd5
  } reg_addr_t;

  // palette, indexed by tile kind, empty slot unused
  localparam logic [15:0] outline_color [0:4] = '{16'h0000, 16'h0000, 16'h0000,
                                                  16'h03e0, 16'h4208};
  localparam logic [15:0] fill_color [0:4] = '{16'h0000, 16'hf800, 16'h07e0,
                                               16'h07e0, 16'h8410};

endpackage
